// File: hw/mc_mem_pkg.sv
// Shared widths, field types and packet formats for the host memory path.
// The host request, the decoded request and the response all live here so
// that the decode, execute and result stages agree on one layout.
// Modules refer to the contents by scoped names.

package mc_mem_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 16;
  localparam int X_W = 3;
  localparam int NUM_COLS = 4;

  // dram field widths, these add up to ADDR_W
  localparam int BA_W = 2;
  localparam int BG_W = 1;
  localparam int RO_W = 6;
  localparam int CO_W = 5;
  localparam int BO_W = 2;

  localparam int NUM_BANKS = (1 << BG_W) * (1 << BA_W);
  localparam int COL_SEL_W = $clog2(NUM_COLS);
  localparam int BANK_SEL_W = BG_W + BA_W;

  // word address inside one column, in dram order
  localparam int WORD_AW = RO_W + BG_W + BA_W + CO_W;
  localparam int MEM_AW = COL_SEL_W + WORD_AW;
  localparam int MEM_WORDS = 1 << MEM_AW;

  // open-row table covers every bank of every column
  localparam int ORT_AW = COL_SEL_W + BANK_SEL_W;
  localparam int ORT_ENTRIES = NUM_COLS * NUM_BANKS;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [X_W-1:0]    col_t;
  typedef logic [RO_W-1:0]   row_t;
  typedef logic [BA_W-1:0]   ba_t;
  typedef logic [BG_W-1:0]   bg_t;
  typedef logic [CO_W-1:0]   co_t;
  typedef logic [BO_W-1:0]   bo_t;

  typedef enum logic {e_load, e_store} mc_op_e;

  typedef enum logic [1:0] {e_ok, e_bad_dest, e_misaligned} mc_status_e;

  typedef enum logic [1:0] {e_idle, e_busy, e_wait_release} hs_state_e;

  // address as the cache side sends it, msb first
  typedef struct packed {
    ba_t  ba;
    bg_t  bg;
    row_t ro;
    co_t  co;
    bo_t  bo;
  } cache_addr_s;

  typedef struct packed {
    row_t ro;
    bg_t  bg;
    ba_t  ba;
    co_t  co;
  } dram_addr_s;

  typedef struct packed {
    mc_op_e op;
    col_t   dest_x;
    addr_t  addr;
    data_t  data;
  } mc_req_pkt_s;

  typedef struct packed {
    mc_op_e     op;
    mc_status_e status;
    col_t       column;
    dram_addr_s addr;
    data_t      data;
  } mc_dec_s;

  typedef struct packed {
    mc_op_e     op;
    mc_status_e status;
    data_t      data;
    logic       row_hit;
  } mc_resp_pkt_s;

endpackage

// File: hw/mc_req_decode.sv
// Host request receiver and decode stage.
// Takes one request per four-phase req/ack exchange when its slot is empty,
// checks the destination column and word alignment, and turns the cache
// address into dram fields. The decoded request goes to the execute stage
// over a valid/ready channel.

`timescale 1ns/1ps

module mc_req_decode (
  input  logic                     clk_i
  , input  logic                   reset_i

  , input  logic                   req_i
  , input  mc_mem_pkg::mc_req_pkt_s req_pkt_i
  , output logic                   ack_o

  , output logic                   dec_valid_o
  , output mc_mem_pkg::mc_dec_s    dec_o
  , input  logic                   dec_ready_i
);

  mc_mem_pkg::hs_state_e   state_q;
  mc_mem_pkg::hs_state_e   state_n;
  mc_mem_pkg::cache_addr_s cache_addr;
  mc_mem_pkg::mc_dec_s     dec_n;
  mc_mem_pkg::mc_dec_s     dec_q;
  logic                    dec_valid_q;
  logic                    capture;

  assign cache_addr = req_pkt_i.addr;

  // field split and request check
  always_comb begin
    dec_n.op      = req_pkt_i.op;
    dec_n.column  = req_pkt_i.dest_x;
    dec_n.addr.ro = cache_addr.ro;
    dec_n.addr.bg = cache_addr.bg;
    dec_n.addr.ba = cache_addr.ba;
    dec_n.addr.co = cache_addr.co;
    dec_n.data    = req_pkt_i.data;

    if (req_pkt_i.dest_x >= mc_mem_pkg::col_t'(mc_mem_pkg::NUM_COLS)) begin
      dec_n.status = mc_mem_pkg::e_bad_dest;
    end else if (cache_addr.bo != '0) begin
      dec_n.status = mc_mem_pkg::e_misaligned;
    end else begin
      dec_n.status = mc_mem_pkg::e_ok;
    end
  end

  // only sample a new request with the slot empty
  assign capture = (state_q == mc_mem_pkg::e_idle) && req_i && !dec_valid_q;

  always_comb begin
    state_n = state_q;
    case (state_q)
      mc_mem_pkg::e_idle: begin
        if (capture) begin
          state_n = mc_mem_pkg::e_busy;
        end
      end
      mc_mem_pkg::e_busy: begin
        // host released req, drop ack
        if (!req_i) begin
          state_n = mc_mem_pkg::e_idle;
        end
      end
      default: begin
        state_n = mc_mem_pkg::e_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= mc_mem_pkg::e_idle;
      dec_valid_q <= 1'b0;
    end else begin
      state_q <= state_n;
      if (capture) begin
        dec_valid_q <= 1'b1;
      end else if (dec_valid_q && dec_ready_i) begin
        dec_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      dec_q <= dec_n;
    end
  end

  assign ack_o       = (state_q == mc_mem_pkg::e_busy);
  assign dec_valid_o = dec_valid_q;
  assign dec_o       = dec_q;

endmodule

// File: hw/mc_test_dram.sv
// Execute stage: the test dram behind every memory column.
// Holds one decoded request; the cycle after it arrives the word array is
// written or read and the open-row table of the addressed bank is checked
// and updated. The response waits in an output register until the result
// stage takes it. Requests that failed decode leave memory and table alone.

`timescale 1ns/1ps

module mc_test_dram (
  input  logic                      clk_i
  , input  logic                    reset_i

  , input  logic                    dec_valid_i
  , input  mc_mem_pkg::mc_dec_s     dec_i
  , output logic                    dec_ready_o

  , output logic                    res_valid_o
  , output mc_mem_pkg::mc_resp_pkt_s res_o
  , input  logic                    res_ready_i
);

  // word storage, column in the upper index bits
  mc_mem_pkg::data_t mem_q [mc_mem_pkg::MEM_WORDS];

  // open row per column and bank
  mc_mem_pkg::row_t                     open_row_q [mc_mem_pkg::ORT_ENTRIES];
  logic [mc_mem_pkg::ORT_ENTRIES-1:0]   open_vld_q;

  mc_mem_pkg::mc_dec_s      req_q;
  logic                     pend_q;
  mc_mem_pkg::mc_resp_pkt_s res_q;
  logic                     res_valid_q;

  logic [mc_mem_pkg::MEM_AW-1:0] mem_idx;
  logic [mc_mem_pkg::ORT_AW-1:0] ort_idx;
  logic                          accept;
  logic                          req_ok;
  logic                          row_hit;

  // one item in the stage, either pending or finished
  assign dec_ready_o = !pend_q && !res_valid_q;
  assign accept      = dec_valid_i && dec_ready_o;

  assign mem_idx = {req_q.column[mc_mem_pkg::COL_SEL_W-1:0], req_q.addr};
  assign ort_idx = {req_q.column[mc_mem_pkg::COL_SEL_W-1:0], req_q.addr.bg, req_q.addr.ba};

  assign req_ok  = pend_q && (req_q.status == mc_mem_pkg::e_ok);
  assign row_hit = open_vld_q[ort_idx] && (open_row_q[ort_idx] == req_q.addr.ro);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q      <= 1'b0;
      res_valid_q <= 1'b0;
      open_vld_q  <= '0;
    end else begin
      if (accept) begin
        pend_q <= 1'b1;
      end else if (pend_q) begin
        pend_q <= 1'b0;
      end

      if (pend_q) begin
        res_valid_q <= 1'b1;
      end else if (res_valid_q && res_ready_i) begin
        res_valid_q <= 1'b0;
      end

      if (req_ok) begin
        open_vld_q[ort_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= dec_i;
    end
    // bank now has this row open
    if (req_ok) begin
      open_row_q[ort_idx] <= req_q.addr.ro;
    end
  end

  // memory access and response build
  always_ff @(posedge clk_i) begin
    if (req_ok && (req_q.op == mc_mem_pkg::e_store)) begin
      mem_q[mem_idx] <= req_q.data;
    end
    if (pend_q) begin
      res_q.op      <= req_q.op;
      res_q.status  <= req_q.status;
      res_q.row_hit <= req_ok && row_hit;
      if (req_ok && (req_q.op == mc_mem_pkg::e_load)) begin
        res_q.data <= mem_q[mem_idx];
      end else begin
        res_q.data <= '0;
      end
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

endmodule

// File: hw/mc_resp_gen.sv
// Result stage and host response sender.
// Registers one response from the execute stage and returns it over the
// four-phase resp_req/resp_ack channel. The packet stays stable while
// resp_req_o is high, and the next item is taken only after the host has
// released resp_ack_i.

`timescale 1ns/1ps

module mc_resp_gen (
  input  logic                      clk_i
  , input  logic                    reset_i

  , input  logic                    res_valid_i
  , input  mc_mem_pkg::mc_resp_pkt_s res_i
  , output logic                    res_ready_o

  , output logic                    resp_req_o
  , output mc_mem_pkg::mc_resp_pkt_s resp_pkt_o
  , input  logic                    resp_ack_i
);

  mc_mem_pkg::hs_state_e    state_q;
  mc_mem_pkg::hs_state_e    state_n;
  mc_mem_pkg::mc_resp_pkt_s resp_q;
  logic                     load_resp;

  assign res_ready_o = (state_q == mc_mem_pkg::e_idle);
  assign load_resp   = res_ready_o && res_valid_i;

  always_comb begin
    state_n = state_q;
    case (state_q)
      mc_mem_pkg::e_idle: begin
        if (load_resp) begin
          state_n = mc_mem_pkg::e_busy;
        end
      end
      mc_mem_pkg::e_busy: begin
        if (resp_ack_i) begin
          state_n = mc_mem_pkg::e_wait_release;
        end
      end
      mc_mem_pkg::e_wait_release: begin
        // wait for host to drop ack
        if (!resp_ack_i) begin
          state_n = mc_mem_pkg::e_idle;
        end
      end
      default: begin
        state_n = mc_mem_pkg::e_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= mc_mem_pkg::e_idle;
    end else begin
      state_q <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_resp) begin
      resp_q <= res_i;
    end
  end

  assign resp_req_o = (state_q == mc_mem_pkg::e_busy);
  assign resp_pkt_o = resp_q;

endmodule

// File: hw/mc_io_mem_top.sv
// Top of the host memory path.
// Chains the decode, execute and result stages; the host sees one
// four-phase request channel in and one four-phase response channel out.
// Up to three requests can be in flight, answered in request order.

`timescale 1ns/1ps

module mc_io_mem_top (
  input  logic                      clk_i
  , input  logic                    reset_i

  , input  logic                    req_i
  , input  mc_mem_pkg::mc_req_pkt_s req_pkt_i
  , output logic                    ack_o

  , output logic                    resp_req_o
  , output mc_mem_pkg::mc_resp_pkt_s resp_pkt_o
  , input  logic                    resp_ack_i
);

  logic                     dec_valid;
  mc_mem_pkg::mc_dec_s      dec;
  logic                     dec_ready;

  logic                     res_valid;
  mc_mem_pkg::mc_resp_pkt_s res;
  logic                     res_ready;

  mc_req_decode u_decode (
    .clk_i        (clk_i)
    ,.reset_i     (reset_i)
    ,.req_i       (req_i)
    ,.req_pkt_i   (req_pkt_i)
    ,.ack_o       (ack_o)
    ,.dec_valid_o (dec_valid)
    ,.dec_o       (dec)
    ,.dec_ready_i (dec_ready)
  );

  mc_test_dram u_execute (
    .clk_i        (clk_i)
    ,.reset_i     (reset_i)
    ,.dec_valid_i (dec_valid)
    ,.dec_i       (dec)
    ,.dec_ready_o (dec_ready)
    ,.res_valid_o (res_valid)
    ,.res_o       (res)
    ,.res_ready_i (res_ready)
  );

  mc_resp_gen u_result (
    .clk_i        (clk_i)
    ,.reset_i     (reset_i)
    ,.res_valid_i (res_valid)
    ,.res_i       (res)
    ,.res_ready_o (res_ready)
    ,.resp_req_o  (resp_req_o)
    ,.resp_pkt_o  (resp_pkt_o)
    ,.resp_ack_i  (resp_ack_i)
  );

endmodule

// File: sim/tb_mc_io_mem_tasks.svh
// Tasks of the memory path testbench, included inside tb_mc_io_mem.
// Holds the LFSR, request and address builders, the reference prediction,
// both host handshakes, the compare tasks and the directed tests.

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        out_bit;
  int          i;
  val = '0;
  for (i = 0; i < n; i++) begin
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    val = {val[30:0], out_bit};
  end
  return val;
endfunction

// cache format, msb first: ba, bg, ro, co, byte offset
function automatic mc_mem_pkg::addr_t make_addr(input logic [1:0] ba, input logic bg,
                                                input logic [5:0] ro, input logic [4:0] co);
  return {ba, bg, ro, co, 2'b00};
endfunction

function automatic mc_mem_pkg::mc_req_pkt_s make_req(input mc_mem_pkg::mc_op_e op,
    input mc_mem_pkg::col_t dest, input mc_mem_pkg::addr_t addr, input mc_mem_pkg::data_t data);
  mc_mem_pkg::mc_req_pkt_s p;
  p.op     = op;
  p.dest_x = dest;
  p.addr   = addr;
  p.data   = data;
  return p;
endfunction

// expected response, updates the reference memory and row table
function automatic mc_mem_pkg::mc_resp_pkt_s predict(input mc_mem_pkg::mc_req_pkt_s p);
  mc_mem_pkg::mc_resp_pkt_s r;
  int                       bank;
  int                       key;
  logic [5:0]               row;
  r.op      = p.op;
  r.data    = '0;
  r.row_hit = 1'b0;
  if (p.dest_x >= 4) begin
    r.status = mc_mem_pkg::e_bad_dest;
  end else if (p.addr[1:0] != 2'b00) begin
    r.status = mc_mem_pkg::e_misaligned;
  end else begin
    r.status  = mc_mem_pkg::e_ok;
    row       = p.addr[12:7];
    bank      = int'(p.dest_x) * 8 + int'({p.addr[13], p.addr[15:14]});
    key       = int'({p.dest_x, p.addr});
    r.row_hit = ref_vld[bank] && (ref_row[bank] == row);
    ref_vld[bank] = 1'b1;
    ref_row[bank] = row;
    if (p.op == mc_mem_pkg::e_store) begin
      ref_mem[key] = p.data;
    end else if (ref_mem.exists(key)) begin
      r.data = ref_mem[key];
    end
  end
  return r;
endfunction

task automatic cmp_data(input mc_mem_pkg::data_t exp, input mc_mem_pkg::data_t got,
                        input string what);
  if (got !== exp) begin
    $display("error at %0t ns: %s data expected %h got %h", $time, what, exp, got);
    fail_cnt++;
  end else begin
    pass_cnt++;
  end
endtask

task automatic cmp_status(input mc_mem_pkg::mc_status_e exp, input mc_mem_pkg::mc_status_e got,
                          input string what);
  if (got !== exp) begin
    $display("error at %0t ns: %s status expected %s got %s", $time, what, exp.name(),
             got.name());
    fail_cnt++;
  end else begin
    pass_cnt++;
  end
endtask

task automatic cmp_op(input mc_mem_pkg::mc_op_e exp, input mc_mem_pkg::mc_op_e got,
                      input string what);
  if (got !== exp) begin
    $display("error at %0t ns: %s op expected %s got %s", $time, what, exp.name(),
             got.name());
    fail_cnt++;
  end else begin
    pass_cnt++;
  end
endtask

task automatic cmp_bit(input logic exp, input logic got, input string what);
  if (got !== exp) begin
    $display("error at %0t ns: %s expected %b got %b", $time, what, exp, got);
    fail_cnt++;
  end else begin
    pass_cnt++;
  end
endtask

// host side of the request channel
task automatic send_req(input mc_mem_pkg::mc_req_pkt_s p);
  exp_q.push_back(predict(p));
  @(posedge clk_i);
  req_pkt_i <= p;
  req_i     <= 1'b1;
  do begin
    @(posedge clk_i);
  end while (!ack_o);
  req_i <= 1'b0;
  do begin
    @(posedge clk_i);
  end while (ack_o);
endtask

// host side of the response channel, ack held back by delay cycles
task automatic recv_resp(input int delay, output mc_mem_pkg::mc_resp_pkt_s p);
  do begin
    @(posedge clk_i);
  end while (!resp_req_o);
  p = resp_pkt_o;
  repeat (delay) @(posedge clk_i);
  resp_ack_i <= 1'b1;
  do begin
    @(posedge clk_i);
  end while (resp_req_o);
  resp_ack_i <= 1'b0;
endtask

task automatic check_next(input int delay);
  mc_mem_pkg::mc_resp_pkt_s got;
  mc_mem_pkg::mc_resp_pkt_s exp;
  string                    what;
  recv_resp(delay, got);
  resp_cnt++;
  what = $sformatf("%s resp %0d", cur_test, resp_cnt);
  if (exp_q.size() == 0) begin
    $display("%s arrived with no request outstanding", what);
    fail_cnt++;
  end else begin
    exp = exp_q.pop_front();
    cmp_op(exp.op, got.op, what);
    cmp_data(exp.data, got.data, what);
    cmp_status(exp.status, got.status, what);
    cmp_bit(exp.row_hit, got.row_hit, {what, " row_hit"});
  end
endtask

task automatic run_txn(input mc_mem_pkg::mc_req_pkt_s p);
  send_req(p);
  check_next(0);
endtask

task automatic start_test(input string name);
  cur_test       = name;
  test_fail_base = fail_cnt;
endtask

task automatic end_test();
  $display("test %-14s done, %0d errors", cur_test, fail_cnt - test_fail_base);
endtask

task automatic test_reset();
  int i;
  start_test("reset");
  for (i = 0; i < 8; i++) begin
    @(posedge clk_i);
    cmp_bit(1'b0, ack_o, "ack_o after reset");
    cmp_bit(1'b0, resp_req_o, "resp_req_o after reset");
  end
  end_test();
endtask

task automatic test_round_trip();
  mc_mem_pkg::col_t  col [12];
  mc_mem_pkg::addr_t addr [12];
  int                i;
  start_test("round_trip");
  for (i = 0; i < 12; i++) begin
    col[i]  = mc_mem_pkg::col_t'(rand_bits(2));
    addr[i] = mc_mem_pkg::addr_t'(rand_bits(14) << 2);
    run_txn(make_req(mc_mem_pkg::e_store, col[i], addr[i], rand_bits(32)));
  end
  for (i = 0; i < 12; i++) begin
    run_txn(make_req(mc_mem_pkg::e_load, col[i], addr[i], '0));
  end
  end_test();
endtask

task automatic test_column_indep();
  mc_mem_pkg::addr_t a;
  int                c;
  start_test("column_indep");
  a = mc_mem_pkg::addr_t'(rand_bits(14) << 2);
  for (c = 0; c < 4; c++) begin
    run_txn(make_req(mc_mem_pkg::e_store, mc_mem_pkg::col_t'(c), a, rand_bits(32)));
  end
  for (c = 0; c < 4; c++) begin
    run_txn(make_req(mc_mem_pkg::e_load, mc_mem_pkg::col_t'(c), a, '0));
  end
  end_test();
endtask

task automatic test_row_hit();
  mc_mem_pkg::addr_t a;
  start_test("row_hit");
  a = make_addr(2'd2, 1'b1, 6'd10, 5'd3);
  // miss, then hits on the same row
  run_txn(make_req(mc_mem_pkg::e_store, 3'd1, a, rand_bits(32)));
  run_txn(make_req(mc_mem_pkg::e_load, 3'd1, a, '0));
  run_txn(make_req(mc_mem_pkg::e_store, 3'd1, make_addr(2'd2, 1'b1, 6'd10, 5'd7), 32'h1));
  // other bank and other column leave this entry alone
  run_txn(make_req(mc_mem_pkg::e_store, 3'd1, make_addr(2'd1, 1'b0, 6'd33, 5'd0), 32'h2));
  run_txn(make_req(mc_mem_pkg::e_store, 3'd2, make_addr(2'd2, 1'b1, 6'd12, 5'd3), 32'h3));
  run_txn(make_req(mc_mem_pkg::e_load, 3'd1, a, '0));
  run_txn(make_req(mc_mem_pkg::e_store, 3'd1, make_addr(2'd2, 1'b1, 6'd11, 5'd3), 32'h4));
  run_txn(make_req(mc_mem_pkg::e_load, 3'd1, a, '0));
  end_test();
endtask

task automatic test_error_reqs();
  mc_mem_pkg::addr_t a;
  mc_mem_pkg::addr_t b;
  int                d;
  start_test("error_reqs");
  a = make_addr(2'd3, 1'b0, 6'd20, 5'd5);
  b = make_addr(2'd3, 1'b0, 6'd21, 5'd5);
  run_txn(make_req(mc_mem_pkg::e_store, 3'd0, a, rand_bits(32)));
  // dest 4 would alias column 0 on the stored word and on another row of its bank
  for (d = 4; d < 8; d++) begin
    run_txn(make_req(mc_mem_pkg::e_store, mc_mem_pkg::col_t'(d), a, ~32'h0));
  end
  run_txn(make_req(mc_mem_pkg::e_store, 3'd4, b, ~32'h0));
  run_txn(make_req(mc_mem_pkg::e_store, 3'd0, a | 16'h1, 32'hdead_0001));
  run_txn(make_req(mc_mem_pkg::e_store, 3'd0, b | 16'h2, 32'hdead_0002));
  run_txn(make_req(mc_mem_pkg::e_load, 3'd0, a, '0));
  end_test();
endtask

task automatic test_back_pressure();
  mc_mem_pkg::mc_req_pkt_s bp_req [16];
  int                      bp_delay [16];
  int                      i;
  int                      j;
  start_test("back_pressure");
  // all stimulus drawn up front so both host sides stay independent
  for (i = 0; i < 8; i++) begin
    bp_req[i] = make_req(mc_mem_pkg::e_store, mc_mem_pkg::col_t'(rand_bits(2)),
                         mc_mem_pkg::addr_t'(rand_bits(14) << 2), rand_bits(32));
    bp_req[i + 8] = make_req(mc_mem_pkg::e_load, bp_req[i].dest_x, bp_req[i].addr, '0);
  end
  for (i = 0; i < 16; i++) begin
    bp_delay[i] = int'(rand_bits(3));
  end
  fork
    begin
      for (i = 0; i < 16; i++) begin
        send_req(bp_req[i]);
      end
    end
    begin
      for (j = 0; j < 16; j++) begin
        check_next(bp_delay[j]);
      end
    end
  join
  // no extra response may follow the burst
  repeat (10) begin
    @(posedge clk_i);
    cmp_bit(1'b0, resp_req_o, "resp_req_o after burst");
  end
  if (exp_q.size() != 0) begin
    $display("%0d expected responses never arrived", exp_q.size());
    fail_cnt++;
  end
  end_test();
endtask

// File: sim/tb_mc_io_mem.sv
// Testbench for the host memory path.
// Drives the four-phase request channel, answers the four-phase response
// channel and checks every response against a reference word memory and
// open-row table kept here. Compile with sim.f, top is tb_mc_io_mem.

`timescale 1ns/1ps

module tb_mc_io_mem;

  // 40 cycles per transaction, plus slack for reset and idle checks
  localparam int NUM_TXN = 65;
  localparam int MAX_CYCLES = 40 * NUM_TXN + 200;

  logic                     clk_i;
  logic                     reset_i;
  logic                     req_i;
  mc_mem_pkg::mc_req_pkt_s  req_pkt_i;
  logic                     ack_o;
  logic                     resp_req_o;
  mc_mem_pkg::mc_resp_pkt_s resp_pkt_o;
  logic                     resp_ack_i;

  int          pass_cnt;
  int          fail_cnt;
  int          test_fail_base;
  int          cycle_cnt;
  int          resp_cnt;
  string       cur_test;
  logic [31:0] lfsr_state;

  // reference model, bank index is column * 8 + {bg, ba}
  mc_mem_pkg::data_t        ref_mem [int];
  mc_mem_pkg::row_t         ref_row [32];
  logic [31:0]              ref_vld;
  mc_mem_pkg::mc_resp_pkt_s exp_q [$];

  `include "tb_mc_io_mem_tasks.svh"

  mc_io_mem_top u_mc_io_mem_top (
    .clk_i       (clk_i)
    ,.reset_i    (reset_i)
    ,.req_i      (req_i)
    ,.req_pkt_i  (req_pkt_i)
    ,.ack_o      (ack_o)
    ,.resp_req_o (resp_req_o)
    ,.resp_pkt_o (resp_pkt_o)
    ,.resp_ack_i (resp_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run not finished after %0d cycles, a handshake is stuck", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    reset_i    = 1'b1;
    req_i      = 1'b0;
    req_pkt_i  = '0;
    resp_ack_i = 1'b0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    resp_cnt   = 0;
    ref_vld    = '0;
    lfsr_state = 32'hd5b5_236d;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    test_reset();
    test_round_trip();
    test_column_indep();
    test_row_hit();
    test_error_reqs();
    test_back_pressure();

    $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+sim
hw/mc_mem_pkg.sv
hw/mc_req_decode.sv
hw/mc_test_dram.sv
hw/mc_resp_gen.sv
hw/mc_io_mem_top.sv
sim/tb_mc_io_mem.sv
